// ==== hdl/qspi_pkg.sv ====
`default_nettype none

package qspi_pkg;

	//////////////////////////////
	// Sizes

	// Divider from the APB clock to half an SCK period
	localparam int CLKDIV_W     = 16;
	localparam int CLKDIV_RESET = 100;

	// Burst read limits
	localparam int BURST_MAX    = 256;
	localparam int BURST_LEN_W  = 9;

	// Receive buffer of 32 bit words
	localparam int BUF_DEPTH    = 64;
	localparam int BUF_ADDR_W   = 6;

	//////////////////////////////
	// Register map

	// Offsets spaced 0x20 apart
	typedef enum logic [8:0] {
		REG_CLK_DIV     = 9'h000,
		REG_DATA        = 9'h020,
		REG_CS_N        = 9'h040,
		REG_STATUS      = 9'h060,
		REG_STATUS_2    = 9'h080,
		REG_BURST_RDLEN = 9'h0a0,
		REG_QUAD_CAP    = 9'h0c0,
		// Receive buffer window, everything from here up
		REG_BURST_RXBUF = 9'h100
	} reg_addr_t;

	//////////////////////////////
	// APB completer port

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [8:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic        pslverr;
		logic [31:0] prdata;
	} apb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/qspi_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module qspi_regs (
	input  wire logic                                apb,
	input  wire logic                                arst_n,
	input  wire qspi_pkg::apb_req_t                  req,
	output qspi_pkg::apb_rsp_t                       rsp,
	output logic [qspi_pkg::CLKDIV_W-1:0]            clk_div,
	output logic                                     cs_n,
	output logic                                     shift_start,
	output logic [7:0]                               tx_byte,
	input  wire logic [7:0]                          rx_byte,
	input  wire logic                                shift_done,
	output logic                                     burst_start,
	output logic [qspi_pkg::BURST_LEN_W-1:0]         burst_len,
	input  wire logic                                burst_next,
	input  wire logic                                burst_busy,
	output logic [qspi_pkg::BUF_ADDR_W-1:0]          buf_raddr,
	input  wire logic [31:0]                         buf_rdata
);
	import qspi_pkg::*;

	logic        acc;
	logic        wr;
	logic        busy;
	logic        shift_busy;
	logic        data_start;
	logic        wr_err;
	logic        rd_err;
	logic [31:0] rd_data;

	//////////////////////////////
	// Access decode

	// Zero wait states
	assign acc  = req.psel && req.penable;
	assign wr   = acc && req.pwrite;
	assign busy = shift_busy || burst_busy;

	// Writes while busy are dropped
	assign data_start  = wr && (req.paddr == REG_DATA) && !busy;
	assign burst_start = wr && (req.paddr == REG_BURST_RDLEN) && (req.pwdata != '0) && !busy;

	// Clamp to one full buffer
	assign burst_len = (req.pwdata > 32'(BURST_MAX)) ? BURST_LEN_W'(BURST_MAX)
		: req.pwdata[BURST_LEN_W-1:0];

	// Word index into the receive buffer
	assign buf_raddr = req.paddr[BUF_ADDR_W+1:2];

	//////////////////////////////
	// Read mux and errors

	always_comb begin
		rd_data = '0;
		wr_err  = 1'b0;
		rd_err  = 1'b0;
		case (req.paddr)
			REG_CLK_DIV:     rd_data = 32'(clk_div);
			REG_DATA:        rd_data = {24'h0, rx_byte};
			REG_CS_N:        rd_data = {31'h0, cs_n};
			// Status is read only
			REG_STATUS, REG_STATUS_2: begin
				rd_data = {31'h0, busy};
				wr_err  = 1'b1;
			end
			// Write only, reads as zero
			REG_BURST_RDLEN: rd_data = '0;
			REG_QUAD_CAP: begin
				rd_data = 32'h1;
				wr_err  = 1'b1;
			end
			default: begin
				if (req.paddr >= REG_BURST_RXBUF) begin
					rd_data = buf_rdata;
				end else begin
					rd_err = 1'b1;
				end
				// Buffer and holes both refuse writes
				wr_err = 1'b1;
			end
		endcase
	end

	assign rsp.pready  = acc;
	assign rsp.pslverr = acc && (req.pwrite ? wr_err : rd_err);
	assign rsp.prdata  = (acc && !req.pwrite) ? rd_data : '0;

	//////////////////////////////
	// Control registers

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			clk_div     <= CLKDIV_W'(CLKDIV_RESET);
			cs_n        <= 1'b1;
			shift_start <= 1'b0;
			shift_busy  <= 1'b0;
		end else begin
			// Single byte or next burst byte, launched one clock later
			shift_start <= data_start || burst_next;
			if (data_start || burst_next) begin
				shift_busy <= 1'b1;
			end else if (shift_done) begin
				shift_busy <= 1'b0;
			end
			// Zero divider would stall SCK
			if (wr && (req.paddr == REG_CLK_DIV)) begin
				clk_div <= (req.pwdata[CLKDIV_W-1:0] == '0) ? CLKDIV_W'(1)
					: req.pwdata[CLKDIV_W-1:0];
			end
			if (wr && (req.paddr == REG_CS_N)) begin
				cs_n <= req.pwdata[0];
			end
		end
	end

	// Burst bytes shift out zeros
	always_ff @(posedge apb) begin
		if (data_start || burst_next) begin
			tx_byte <= data_start ? req.pwdata[7:0] : 8'h00;
		end
	end

	// New shift only after the previous one reported done
	a_no_overlap: assert property (@(posedge apb) disable iff (!arst_n)
		shift_start |-> (!$past(shift_busy) || $past(shift_done)));

endmodule

`default_nettype wire

// ==== hdl/qspi_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module qspi_shifter (
	input  wire logic                           apb,
	input  wire logic                           arst_n,
	input  wire logic [qspi_pkg::CLKDIV_W-1:0]  clk_div,
	input  wire logic                           shift_start,
	input  wire logic [7:0]                     tx_byte,
	output logic                                shift_done,
	output logic [7:0]                          rx_byte,
	output logic                                sck,
	output logic [3:0]                          dq_out,
	input  wire logic [3:0]                     dq_in,
	output logic [3:0]                          dq_tris
);
	import qspi_pkg::*;

	logic                active;
	logic [CLKDIV_W-1:0] div_cnt;
	logic [4:0]          edge_cnt;
	logic [7:0]          shreg;
	logic                sample;
	logic                tick;
	logic                finish;

	// Half SCK period elapsed
	assign tick   = active && (div_cnt == clk_div - 1'b1);
	// Tail after the 16th edge
	assign finish = tick && (edge_cnt == 5'd16);

	// Single lane, MSB first on dq[0]
	assign dq_out  = {3'b000, active && shreg[7]};
	// High bit means the lane is driven
	assign dq_tris = {3'b000, active};

	//////////////////////////////
	// SCK and sequencing

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			active     <= 1'b0;
			div_cnt    <= '0;
			edge_cnt   <= '0;
			sck        <= 1'b0;
			shift_done <= 1'b0;
		end else begin
			shift_done <= 1'b0;
			if (shift_start) begin
				active   <= 1'b1;
				div_cnt  <= '0;
				edge_cnt <= '0;
			end else if (finish) begin
				active     <= 1'b0;
				div_cnt    <= '0;
				shift_done <= 1'b1;
			end else if (tick) begin
				div_cnt  <= '0;
				sck      <= !sck;
				edge_cnt <= edge_cnt + 5'd1;
			end else if (active) begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Data path

	always_ff @(posedge apb) begin
		if (shift_start) begin
			shreg <= tx_byte;
		end else if (tick && !finish) begin
			// Mode 0 samples on rising SCK
			if (!sck) begin
				sample <= dq_in[1];
			end else begin
				// Falling SCK shifts out next bit and keeps the sample
				shreg <= {shreg[6:0], sample};
			end
		end
		if (finish) begin
			rx_byte <= shreg;
		end
	end

	a_sck_idle: assert property (@(posedge apb) disable iff (!arst_n)
		!active |-> !sck);

	// Next byte only once the current one has ended
	a_start_idle: assert property (@(posedge apb) disable iff (!arst_n)
		shift_start |-> !active);

endmodule

`default_nettype wire

// ==== hdl/qspi_burst.sv ====
`timescale 1ns/10ps
`default_nettype none

module qspi_burst (
	input  wire logic                               apb,
	input  wire logic                               arst_n,
	input  wire logic                               burst_start,
	input  wire logic [qspi_pkg::BURST_LEN_W-1:0]   burst_len,
	input  wire logic                               shift_done,
	input  wire logic [7:0]                         rx_byte,
	output logic                                    burst_next,
	output logic                                    burst_busy,
	input  wire logic [qspi_pkg::BUF_ADDR_W-1:0]    buf_raddr,
	output logic [31:0]                             buf_rdata
);
	import qspi_pkg::*;

	logic [BURST_LEN_W-1:0] remaining;
	logic [1:0]             byte_idx;
	logic [31:0]            word;
	logic                   wr_pending;
	logic                   last_pending;
	logic [BUF_ADDR_W-1:0]  wptr;
	logic [31:0]            mem [BUF_DEPTH];
	logic                   take;

	// Byte arriving for this burst
	assign take = burst_busy && shift_done;

	// First byte on start, then one per done until the count runs out
	assign burst_next = burst_start || (take && (remaining != BURST_LEN_W'(1)));

	// Combinational read port for the APB window
	assign buf_rdata = mem[buf_raddr];

	//////////////////////////////
	// Counters

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			burst_busy   <= 1'b0;
			remaining    <= '0;
			byte_idx     <= '0;
			wr_pending   <= 1'b0;
			last_pending <= 1'b0;
			wptr         <= '0;
		end else begin
			wr_pending <= 1'b0;
			if (burst_start) begin
				burst_busy   <= 1'b1;
				remaining    <= burst_len;
				byte_idx     <= '0;
				last_pending <= 1'b0;
				wptr         <= '0;
			end else begin
				if (take) begin
					remaining    <= remaining - 1'b1;
					byte_idx     <= byte_idx + 2'd1;
					// Full word or final partial word
					wr_pending   <= (byte_idx == 2'd3) || (remaining == BURST_LEN_W'(1));
					last_pending <= (remaining == BURST_LEN_W'(1));
				end
				if (wr_pending) begin
					wptr <= wptr + 1'b1;
					if (last_pending) begin
						burst_busy <= 1'b0;
					end
				end
			end
		end
	end

	//////////////////////////////
	// Little endian packing

	always_ff @(posedge apb) begin
		// Cleared word gives the zero tail
		if (burst_start || wr_pending) begin
			word <= '0;
		end else if (take) begin
			word[8*byte_idx +: 8] <= rx_byte;
		end
		if (wr_pending) begin
			mem[wptr] <= word;
		end
	end

	// Top entry only ever holds the final word
	a_wptr_limit: assert property (@(posedge apb) disable iff (!arst_n)
		(wr_pending && (wptr == BUF_ADDR_W'(BUF_DEPTH - 1))) |-> last_pending);

endmodule

`default_nettype wire

// ==== hdl/qspi_apb_host.sv ====
`timescale 1ns/10ps
`default_nettype none

module qspi_apb_host (
	input  wire logic               apb,
	input  wire logic               arst_n,
	input  wire qspi_pkg::apb_req_t req,
	output qspi_pkg::apb_rsp_t      rsp,
	output logic                    qspi_sck,
	output logic [3:0]              qspi_dq_out,
	input  wire logic [3:0]         qspi_dq_in,
	output logic [3:0]              qspi_dq_tris,
	output logic                    qspi_cs_n
);
	import qspi_pkg::*;

	//////////////////////////////
	// Internal links

	logic [CLKDIV_W-1:0]    clk_div;
	logic                   shift_start;
	logic [7:0]             tx_byte;
	logic                   shift_done;
	logic [7:0]             rx_byte;
	logic                   burst_start;
	logic [BURST_LEN_W-1:0] burst_len;
	logic                   burst_next;
	logic                   burst_busy;
	logic [BUF_ADDR_W-1:0]  buf_raddr;
	logic [31:0]            buf_rdata;

	// Register file, steers the other two
	qspi_regs u_regs (
		.apb, .arst_n, .req, .rsp, .clk_div, .cs_n(qspi_cs_n), .shift_start, .tx_byte,
		.rx_byte, .shift_done, .burst_start, .burst_len, .burst_next, .burst_busy,
		.buf_raddr, .buf_rdata
	);

	// Byte engine on the flash pins
	qspi_shifter u_shifter (
		.apb, .arst_n, .clk_div, .shift_start, .tx_byte, .shift_done, .rx_byte,
		.sck(qspi_sck), .dq_out(qspi_dq_out), .dq_in(qspi_dq_in), .dq_tris(qspi_dq_tris)
	);

	// Burst reads into the buffer
	qspi_burst u_burst (
		.apb, .arst_n, .burst_start, .burst_len, .shift_done, .rx_byte, .burst_next,
		.burst_busy, .buf_raddr, .buf_rdata
	);

endmodule

`default_nettype wire

// ==== tb/spi_target_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_target_model (
	input  wire logic       sck,
	input  wire logic       cs_n,
	input  wire logic [7:0] seed,
	input  wire logic       mosi,
	output logic            miso,
	output logic [7:0]      mosi_byte
);
	logic [7:0] cur;
	logic [2:0] bit_idx;

	//////////////////////////////
	// Byte stream

	// Release of select reloads the seed
	always @(posedge cs_n or negedge sck) begin
		if (cs_n) begin
			cur     <= seed;
			bit_idx <= 3'd7;
		end else begin
			// Mode 0, next bit after each falling SCK edge
			if (bit_idx == 3'd0) begin
				cur     <= cur + 8'd1;
				bit_idx <= 3'd7;
			end else begin
				bit_idx <= bit_idx - 3'd1;
			end
		end
	end

	// MSB first, low while deselected
	assign miso = cs_n ? 1'b0 : cur[bit_idx];

	// Last eight host bits, taken on rising SCK
	always @(posedge sck) begin
		if (!cs_n) begin
			mosi_byte <= {mosi_byte[6:0], mosi};
		end
	end

endmodule

`default_nettype wire

// ==== tb/qspi_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module qspi_tb;
	import qspi_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int MAX_OPS    = 64;
	// test, op, address, data, expected pslverr
	localparam int FIELDS     = 5;

	logic        apb;
	logic        arst_n;
	apb_req_t    req;
	apb_rsp_t    rsp;
	logic        sck;
	logic [3:0]  dq_out;
	logic [3:0]  dq_in;
	logic [3:0]  dq_tris;
	logic        cs_n;
	logic        miso;
	logic [7:0]  seed;
	logic [7:0]  mosi_byte;
	logic [7:0]  exp_tx;
	logic        tx_sent;

	logic [31:0] case_mem [MAX_OPS*FIELDS];
	int          n_ops;
	int          limit;
	int          cycles;
	int          errors;
	int          checks;
	int          test_errors;
	int          test_checks;
	int          tests_run;
	int          tests_failed;

	// Target answers on dq[1] only
	assign dq_in = {2'b00, miso, 1'b0};

	qspi_apb_host i_dut (
		.apb, .arst_n, .req, .rsp, .qspi_sck(sck), .qspi_dq_out(dq_out), .qspi_dq_in(dq_in),
		.qspi_dq_tris(dq_tris), .qspi_cs_n(cs_n)
	);

	// Host lane reaches the target only while it is driven
	spi_target_model i_target (
		.sck, .cs_n, .seed, .mosi(dq_out[0] & dq_tris[0]), .miso, .mosi_byte
	);

	//////////////////////////////
	// Clock and timeout

	initial begin
		apb = 1'b0;
		forever begin
			#(CLK_PERIOD / 2);
			apb = ~apb;
		end
	end

	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge apb);
			cycles++;
		end
		$display("Timeout, the cases did not finish within %0d cycles", cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	//////////////////////////////
	// APB driver

	// Setup and access phase, response sampled a quarter period into access
	task automatic apb_xfer(input logic write, input logic [8:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge apb);
		req.psel    = 1'b1;
		req.penable = 1'b0;
		req.pwrite  = write;
		req.paddr   = addr;
		req.pwdata  = wdata;
		@(negedge apb);
		req.penable = 1'b1;
		#(CLK_PERIOD / 4);
		if (!rsp.pready) begin
			$display("pready stayed low in the access phase at address 0x%03h", addr);
			test_errors++;
		end
		rdata = rsp.prdata;
		err   = rsp.pslverr;
		@(negedge apb);
		req = '0;
	endtask

	task automatic check_val(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		test_checks++;
		if (got !== exp) begin
			$display("FAIL %0t: %s gave 0x%08h, expected 0x%08h", $time, what, got, exp);
			test_errors++;
		end
	endtask

	// Busy bit is the only end marker
	task automatic poll_idle();
		logic [31:0] rdata;
		logic        err;
		rdata = 32'h1;
		while (rdata[0]) begin
			apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
		end
	endtask

	//////////////////////////////
	// Case interpreter

	task automatic run_op(input int idx);
		logic [31:0] op;
		logic [8:0]  addr;
		logic [31:0] data;
		logic        exp_err;
		logic [31:0] rdata;
		logic        err;
		op      = case_mem[idx*FIELDS+1];
		addr    = case_mem[idx*FIELDS+2][8:0];
		data    = case_mem[idx*FIELDS+3];
		exp_err = case_mem[idx*FIELDS+4][0];
		case (op)
			1: begin
				@(negedge apb);
				seed = data[7:0];
			end
			2: begin
				apb_xfer(1'b1, addr, data, rdata, err);
				check_val($sformatf("pslverr of write 0x%03h", addr), 32'(err), 32'(exp_err));
				// Data byte goes out on dq[0], burst bytes shift out zeros
				if (addr == REG_DATA) begin
					exp_tx  = data[7:0];
					tx_sent = 1'b1;
				end else if (addr == REG_BURST_RDLEN && data != '0) begin
					exp_tx  = 8'h00;
					tx_sent = 1'b1;
				end
			end
			3: begin
				poll_idle();
				if (tx_sent) begin
					check_val("byte on dq[0]", 32'(mosi_byte), 32'(exp_tx));
					tx_sent = 1'b0;
				end
			end
			4: begin
				apb_xfer(1'b0, addr, '0, rdata, err);
				check_val($sformatf("pslverr of read 0x%03h", addr), 32'(err), 32'(exp_err));
				check_val($sformatf("read 0x%03h", addr), rdata, data);
			end
			default: begin
				$display("Unknown operation %0d on case line %0d", op, idx);
				test_errors++;
			end
		endcase
	endtask

	task automatic end_test(input int num);
		tests_run++;
		checks += test_checks;
		errors += test_errors;
		if (test_errors == 0) begin
			$display("Test %0d passed, %0d checks", num, test_checks);
		end else begin
			$display("Test %0d failed, %0d of %0d checks wrong", num, test_errors, test_checks);
			tests_failed++;
		end
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		int max_div;
		int cur_test;
		int t;
		req          = '0;
		arst_n       = 1'b0;
		seed         = '0;
		exp_tx       = '0;
		tx_sent      = 1'b0;
		errors       = 0;
		checks       = 0;
		test_errors  = 0;
		test_checks  = 0;
		tests_run    = 0;
		tests_failed = 0;
		for (int i = 0; i < MAX_OPS * FIELDS; i++) begin
			case_mem[i] = '0;
		end
		$readmemh("tb/qspi_cases.txt", case_mem);

		// Op 0 marks the end, largest divider sets the timeout
		n_ops   = 0;
		max_div = CLKDIV_RESET;
		while (n_ops < MAX_OPS && case_mem[n_ops*FIELDS+1] != 0) begin
			if (case_mem[n_ops*FIELDS+1] == 2 && case_mem[n_ops*FIELDS+2] == REG_CLK_DIV
				&& int'(case_mem[n_ops*FIELDS+3]) > max_div) begin
				max_div = int'(case_mem[n_ops*FIELDS+3]);
			end
			n_ops++;
		end
		if (n_ops == 0) begin
			$display("No cases could be read from tb/qspi_cases.txt");
			errors++;
		end
		// Worst case per line is a clamped burst plus its polls
		limit = n_ops * (16 * max_div * 258 + 50) + 20;

		repeat (10) @(negedge apb);
		arst_n = 1'b1;
		if (sck !== 1'b0 || cs_n !== 1'b1 || dq_tris !== 4'h0) begin
			$display("FAIL %0t: pins after reset sck=%b cs_n=%b tris=%h", $time, sck, cs_n,
				dq_tris);
			errors++;
		end

		cur_test = 0;
		for (int i = 0; i < n_ops; i++) begin
			t = int'(case_mem[i*FIELDS]);
			if (t != cur_test) begin
				if (cur_test != 0) begin
					end_test(cur_test);
				end
				cur_test = t;
			end
			run_op(i);
		end
		if (cur_test != 0) begin
			end_test(cur_test);
		end

		$display("Tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
			checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/qspi_cases.txt ====
// Columns: test, op, address, data, expected pslverr (all hex)
// Ops: 1 model seed, 2 APB write, 3 poll status until idle, 4 APB read and compare
1 4 000 00000064 0
1 4 040 00000001 0
1 4 060 00000000 0
1 4 080 00000000 0
1 4 0c0 00000001 0
2 2 000 00000003 0
2 4 000 00000003 0
2 2 000 00000000 0
2 4 000 00000001 0
2 2 040 00000000 0
2 4 040 00000000 0
3 1 000 0000005a 0
3 2 040 00000001 0
3 2 040 00000000 0
3 2 020 000000a5 0
3 3 000 00000000 0
3 4 020 0000005a 0
3 2 020 0000003c 0
3 3 000 00000000 0
3 4 020 0000005b 0
4 1 000 00000010 0
4 2 040 00000001 0
4 2 040 00000000 0
4 2 0a0 0000000a 0
4 3 000 00000000 0
4 4 100 13121110 0
4 4 104 17161514 0
4 4 108 00001918 0
5 1 000 00000020 0
5 2 040 00000001 0
5 2 040 00000000 0
5 2 0a0 0000012c 0
5 3 000 00000000 0
5 4 100 23222120 0
5 4 17c 9f9e9d9c 0
5 4 1fc 1f1e1d1c 0
6 2 060 00000000 1
6 2 0e0 00000000 1
6 4 0e0 00000000 1
6 2 0a0 00000000 0
6 4 060 00000000 0

// ==== all.f ====
hdl/qspi_pkg.sv
hdl/qspi_regs.sv
hdl/qspi_shifter.sv
hdl/qspi_burst.sv
hdl/qspi_apb_host.sv
tb/spi_target_model.sv
tb/qspi_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module qspi_tb -f all.f -o qspi_sim
	@out=$$(./obj_dir/qspi_sim); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
